//--- vlog.f
rtl/sb_cfg_pkg.sv
rtl/sb_instr_pkg.sv
rtl/sb_wb_if.sv
rtl/sb_prio_select.sv
rtl/sb_entry_store.sv
rtl/sb_clobber_table.sv
rtl/sb_operand_fwd.sv
rtl/scoreboard_top.sv
tb/tb_clock_gen.sv
tb/tb_scoreboard.sv

//--- Makefile
# Verilator build and run for the scoreboard testbench
# any variable below can be overridden, e.g. make run JOBS=8

VERILATOR ?= verilator
TOP       ?= tb_scoreboard
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a non-zero exit status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- tb/tb_scoreboard.sv
/*
  scoreboard testbench with a queue model checked against the DUT every cycle
  inputs change on the rising edge and outputs are sampled on the falling edge
*/
`timescale 1ns/1ps
`default_nettype none

module tb_scoreboard
  import sb_cfg_pkg::*;
  import sb_instr_pkg::*;
();

  // the sequence below runs about 450 cycles
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam int unsigned SEED           = 32'ha4c0f03d;

  // expected outputs for one cycle
  typedef struct packed {
    logic                 ready;
    trans_id_t            issue_id;
    logic                 cvalid;
    fu_t                  cfu;
    reg_addr_t            crd;
    xlen_t                cres;
    logic                 cex;
    trans_id_t            cid;
    fu_t [NR_REGS-1:0]    clobber;
    xlen_t                rs1;
    logic                 rs1_v;
    xlen_t                rs2;
    logic                 rs2_v;
  } expect_t;

  logic clk;
  logic rst_n;
  logic decoded_valid, decoded_ready, flush;
  fu_t decoded_fu;
  reg_addr_t decoded_rd;
  trans_id_t issue_trans_id;
  logic      [NR_WB_PORTS-1:0] wb_valid;
  trans_id_t [NR_WB_PORTS-1:0] wb_trans_id;
  xlen_t     [NR_WB_PORTS-1:0] wb_data;
  logic      [NR_WB_PORTS-1:0] wb_ex;
  logic commit_valid, commit_ready, commit_ex;
  fu_t commit_fu;
  reg_addr_t commit_rd;
  xlen_t commit_result;
  trans_id_t commit_trans_id;
  reg_addr_t rs1, rs2;
  xlen_t rs1_data, rs2_data;
  logic rs1_valid, rs2_valid;
  fu_t [NR_REGS-1:0] rd_clobber;

  // queue model with one element per slot
  logic      m_occ  [NR_ENTRIES];
  fu_t       m_fu   [NR_ENTRIES];
  reg_addr_t m_rd   [NR_ENTRIES];
  xlen_t     m_res  [NR_ENTRIES];
  logic      m_done [NR_ENTRIES];
  logic      m_ex   [NR_ENTRIES];
  trans_id_t m_issue, m_commit;
  int        m_cnt;
  int        cycles;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  scoreboard_top i_scoreboard_top (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .flush_i           (flush),
    .decoded_valid_i   (decoded_valid),
    .decoded_ready_o   (decoded_ready),
    .decoded_fu_i      (decoded_fu),
    .decoded_rd_i      (decoded_rd),
    .issue_trans_id_o  (issue_trans_id),
    .wb_valid_i        (wb_valid),
    .wb_trans_id_i     (wb_trans_id),
    .wb_data_i         (wb_data),
    .wb_ex_i           (wb_ex),
    .commit_valid_o    (commit_valid),
    .commit_ready_i    (commit_ready),
    .commit_fu_o       (commit_fu),
    .commit_rd_o       (commit_rd),
    .commit_result_o   (commit_result),
    .commit_ex_o       (commit_ex),
    .commit_trans_id_o (commit_trans_id),
    .rs1_i             (rs1),
    .rs1_o             (rs1_data),
    .rs1_valid_o       (rs1_valid),
    .rs2_i             (rs2),
    .rs2_o             (rs2_data),
    .rs2_valid_o       (rs2_valid),
    .rd_clobber_o      (rd_clobber)
  );

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // write-back lanes in port order and then finished slots in slot order
  function automatic logic fwd_lookup(input reg_addr_t rs, output xlen_t data);
    logic hit;
    hit  = 1'b0;
    data = '0;
    for (int p = 0; p < NR_WB_PORTS; p++) begin
      if (!hit && wb_valid[p] && !wb_ex[p] && m_occ[wb_trans_id[p]]
          && m_rd[wb_trans_id[p]] == rs) begin
        hit  = 1'b1;
        data = wb_data[p];
      end
    end
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (!hit && m_occ[i] && m_done[i] && !m_ex[i] && m_rd[i] == rs) begin
        hit  = 1'b1;
        data = m_res[i];
      end
    end
    return hit;
  endfunction

  function automatic expect_t ref_model_outputs();
    expect_t e;
    xlen_t   d;
    logic    found;
    e          = '0;
    e.ready    = (m_cnt < NR_ENTRIES);
    e.issue_id = m_issue;
    e.cvalid   = m_occ[m_commit] && m_done[m_commit];
    e.cfu      = m_fu[m_commit];
    e.crd      = m_rd[m_commit];
    e.cres     = m_res[m_commit];
    e.cex      = m_ex[m_commit];
    e.cid      = m_commit;
    // x0 stays FU_NONE from the clear above
    for (int r = 1; r < NR_REGS; r++) begin
      found = 1'b0;
      for (int i = 0; i < NR_ENTRIES; i++) begin
        if (!found && m_occ[i] && m_rd[i] == reg_addr_t'(r)) begin
          found        = 1'b1;
          e.clobber[r] = m_fu[i];
        end
      end
    end
    e.rs1_v = fwd_lookup(rs1, d) && (rs1 != '0);
    e.rs1   = d;
    e.rs2_v = fwd_lookup(rs2, d) && (rs2 != '0);
    e.rs2   = d;
    return e;
  endfunction

  // state after the coming edge from the inputs held in this cycle
  task automatic advance_model();
    logic occ_old [NR_ENTRIES];
    logic acc;
    logic fire;
    acc  = decoded_valid && (m_cnt < NR_ENTRIES);
    fire = m_occ[m_commit] && m_done[m_commit] && commit_ready;
    for (int i = 0; i < NR_ENTRIES; i++) begin
      occ_old[i] = m_occ[i];
    end
    if (flush) begin
      for (int i = 0; i < NR_ENTRIES; i++) begin
        m_occ[i]  = 1'b0;
        m_done[i] = 1'b0;
        m_ex[i]   = 1'b0;
      end
      m_issue  = '0;
      m_commit = '0;
      m_cnt    = 0;
    end else begin
      for (int i = 0; i < NR_ENTRIES; i++) begin
        if (occ_old[i] && m_fu[i] == FU_NONE) m_done[i] = 1'b1;
      end
      for (int p = 0; p < NR_WB_PORTS; p++) begin
        if (wb_valid[p] && occ_old[wb_trans_id[p]]) begin
          m_res[wb_trans_id[p]]  = wb_data[p];
          m_ex[wb_trans_id[p]]   = wb_ex[p];
          m_done[wb_trans_id[p]] = 1'b1;
        end
      end
      if (fire) begin
        m_occ[m_commit] = 1'b0;
        m_done[m_commit] = 1'b0;
        m_commit = m_commit + trans_id_t'(1);
        m_cnt--;
      end
      if (acc) begin
        m_occ[m_issue]  = 1'b1;
        m_fu[m_issue]   = decoded_fu;
        m_rd[m_issue]   = decoded_rd;
        m_res[m_issue]  = '0;
        m_done[m_issue] = 1'b0;
        m_ex[m_issue]   = 1'b0;
        m_issue = m_issue + trans_id_t'(1);
        m_cnt++;
      end
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ----------------------------------------
  // compare and then step the model
  // ----------------------------------------
  always @(negedge clk) begin
    expect_t e;
    if (!rst_n) begin
      for (int i = 0; i < NR_ENTRIES; i++) begin
        m_occ[i]  = 1'b0;
        m_done[i] = 1'b0;
        m_ex[i]   = 1'b0;
      end
      m_issue  = '0;
      m_commit = '0;
      m_cnt    = 0;
    end else begin
      e = ref_model_outputs();
      check_value("decoded_ready_o", 64'(decoded_ready), 64'(e.ready));
      check_value("issue_trans_id_o", 64'(issue_trans_id), 64'(e.issue_id));
      check_value("commit_valid_o", 64'(commit_valid), 64'(e.cvalid));
      if (e.cvalid) begin
        check_value("commit_fu_o", 64'(commit_fu), 64'(e.cfu));
        check_value("commit_rd_o", 64'(commit_rd), 64'(e.crd));
        check_value("commit_result_o", 64'(commit_result), 64'(e.cres));
        check_value("commit_ex_o", 64'(commit_ex), 64'(e.cex));
        check_value("commit_trans_id_o", 64'(commit_trans_id), 64'(e.cid));
      end
      for (int r = 0; r < NR_REGS; r++) begin
        check_value($sformatf("rd_clobber_o[%0d]", r), 64'(rd_clobber[r]),
                    64'(e.clobber[r]));
      end
      check_value("rs1_valid_o", 64'(rs1_valid), 64'(e.rs1_v));
      if (e.rs1_v) check_value("rs1_o", 64'(rs1_data), 64'(e.rs1));
      check_value("rs2_valid_o", 64'(rs2_valid), 64'(e.rs2_v));
      if (e.rs2_v) check_value("rs2_o", 64'(rs2_data), 64'(e.rs2));
      advance_model();
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  // fu_mode 0 picks a real unit and 1 picks FU_NONE while other values pick any kind
  task automatic drive_cycle(input logic dv, input logic cr, input logic do_wb,
                             input logic fl, input int fu_mode);
    int                          cand [$];
    int                          idx;
    logic      [NR_WB_PORTS-1:0] v;
    logic      [NR_WB_PORTS-1:0] ex;
    trans_id_t [NR_WB_PORTS-1:0] tid;
    xlen_t     [NR_WB_PORTS-1:0] data;
    @(posedge clk);
    // slots still waiting for a unit after this edge
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (m_occ[i] && !m_done[i] && m_fu[i] != FU_NONE) cand.push_back(i);
    end
    v   = '0;
    ex  = '0;
    tid = '0;
    for (int p = 0; p < NR_WB_PORTS; p++) begin
      data[p] = $urandom();
      if (do_wb && cand.size() > 0 && $urandom_range(0, 99) < 60) begin
        idx = int'($urandom_range(0, cand.size() - 1));
        tid[p] = trans_id_t'(cand[idx]);
        cand.delete(idx);
        v[p]  = 1'b1;
        ex[p] = ($urandom_range(0, 7) == 0);
      end
    end
    case (fu_mode)
      0:       decoded_fu <= fu_t'($urandom_range(1, 3));
      1:       decoded_fu <= FU_NONE;
      default: decoded_fu <= fu_t'($urandom_range(0, 3));
    endcase
    decoded_valid <= dv;
    decoded_rd    <= reg_addr_t'($urandom_range(0, 7));
    commit_ready  <= cr;
    flush         <= fl;
    wb_valid      <= v;
    wb_trans_id   <= tid;
    wb_data       <= data;
    wb_ex         <= ex;
    // low registers so reads hit pending writers and x0
    rs1           <= reg_addr_t'($urandom_range(0, 7));
    rs2           <= reg_addr_t'($urandom_range(0, 7));
  endtask

  task automatic drain_queue();
    do begin
      drive_cycle(1'b0, 1'b1, 1'b1, 1'b0, 0);
    end while (m_cnt != 0);
  endtask

  task automatic random_traffic(input int n);
    repeat (n) begin
      drive_cycle($urandom_range(0, 9) < 7, $urandom_range(0, 9) < 6, 1'b1, 1'b0, 2);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    cycles <= 0;
    decoded_valid <= 1'b0;
    decoded_fu    <= FU_NONE;
    decoded_rd    <= '0;
    commit_ready  <= 1'b0;
    flush         <= 1'b0;
    wb_valid      <= '0;
    wb_trans_id   <= '0;
    wb_data       <= '0;
    wb_ex         <= '0;
    rs1           <= '0;
    rs2           <= '0;
    @(posedge rst_n);

    // fill all eight slots with commit held off
    repeat (12) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 0);
    @(negedge clk);
    check_value("decoded_ready_o", 64'(decoded_ready), 64'(0));
    check_value("issue_trans_id_o", 64'(issue_trans_id), 64'(0));
    drain_queue();

    // FU_NONE retire without write-back
    repeat (10) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1);
    drain_queue();

    // out-of-order results with in-order retire
    random_traffic(300);
    drain_queue();

    // flush in the middle of traffic
    random_traffic(40);
    drive_cycle(1'b1, 1'b1, 1'b1, 1'b1, 2);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 0);
    @(negedge clk);
    check_value("commit_valid_o", 64'(commit_valid), 64'(0));
    check_value("issue_trans_id_o", 64'(issue_trans_id), 64'(0));
    for (int r = 0; r < NR_REGS; r++) begin
      check_value($sformatf("rd_clobber_o[%0d]", r), 64'(rd_clobber[r]), 64'(FU_NONE));
    end
    random_traffic(20);
    drain_queue();

    @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
/*
  testbench clock and reset, 4 ns period
  reset is low for two rising edges and released on an edge
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter real         HALF_PERIOD  = 2.0,
  parameter int unsigned RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release through an nba so the dut sees reset on the last edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- rtl/scoreboard_top.sv
/*
  scoreboard top: queue store plus clobber and forwarding readout
  results on wb pins must target slots handed out by issue_trans_id_o
*/
`timescale 1ns/1ps
`default_nettype none

module scoreboard_top
  import sb_cfg_pkg::*;
  import sb_instr_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  // decode side
  input  logic                         decoded_valid_i,
  output logic                         decoded_ready_o,
  input  fu_t                          decoded_fu_i,
  input  reg_addr_t                    decoded_rd_i,
  output trans_id_t                    issue_trans_id_o,
  // write-back pins, one lane per port
  input  logic      [NR_WB_PORTS-1:0]  wb_valid_i,
  input  trans_id_t [NR_WB_PORTS-1:0]  wb_trans_id_i,
  input  xlen_t     [NR_WB_PORTS-1:0]  wb_data_i,
  input  logic      [NR_WB_PORTS-1:0]  wb_ex_i,
  // commit side
  output logic                         commit_valid_o,
  input  logic                         commit_ready_i,
  output fu_t                          commit_fu_o,
  output reg_addr_t                    commit_rd_o,
  output xlen_t                        commit_result_o,
  output logic                         commit_ex_o,
  output trans_id_t                    commit_trans_id_o,
  // operand read
  input  reg_addr_t                    rs1_i,
  output xlen_t                        rs1_o,
  output logic                         rs1_valid_o,
  input  reg_addr_t                    rs2_i,
  output xlen_t                        rs2_o,
  output logic                         rs2_valid_o,
  // pending writers
  output fu_t       [NR_REGS-1:0]      rd_clobber_o
);

  sb_entry_t                  commit_entry;
  sb_entry_t [NR_ENTRIES-1:0] entries;
  logic      [NR_ENTRIES-1:0] occupied;

  // ----------------------------------------
  // write-back bus
  // ----------------------------------------
  sb_wb_if i_wb ();

  assign i_wb.valid    = wb_valid_i;
  assign i_wb.trans_id = wb_trans_id_i;
  assign i_wb.data     = wb_data_i;
  assign i_wb.ex       = wb_ex_i;

  // ----------------------------------------
  // blocks
  // ----------------------------------------
  sb_entry_store i_entry_store (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .decoded_valid_i   (decoded_valid_i),
    .decoded_ready_o   (decoded_ready_o),
    .decoded_fu_i      (decoded_fu_i),
    .decoded_rd_i      (decoded_rd_i),
    .issue_trans_id_o  (issue_trans_id_o),
    .wb                (i_wb),
    .commit_valid_o    (commit_valid_o),
    .commit_ready_i    (commit_ready_i),
    .commit_entry_o    (commit_entry),
    .commit_trans_id_o (commit_trans_id_o),
    .entries_o         (entries),
    .occupied_o        (occupied)
  );

  sb_clobber_table i_clobber_table (
    .entries_i    (entries),
    .occupied_i   (occupied),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd i_operand_fwd (
    .entries_i   (entries),
    .occupied_i  (occupied),
    .wb          (i_wb),
    .rs1_i       (rs1_i),
    .rs1_o       (rs1_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_i       (rs2_i),
    .rs2_o       (rs2_o),
    .rs2_valid_o (rs2_valid_o)
  );

  // head entry split onto the commit pins
  assign commit_fu_o     = commit_entry.fu;
  assign commit_rd_o     = commit_entry.rd;
  assign commit_result_o = commit_entry.result;
  assign commit_ex_o     = commit_entry.ex_valid;

endmodule

`default_nettype wire

//--- rtl/sb_operand_fwd.sv
/*
  forwarding of rs1 and rs2 from result buses and finished slots
  results with an exception never forward, x0 is never valid
*/
`timescale 1ns/1ps
`default_nettype none

module sb_operand_fwd
  import sb_cfg_pkg::*;
  import sb_instr_pkg::*;
(
  input  sb_entry_t [NR_ENTRIES-1:0] entries_i,
  input  logic      [NR_ENTRIES-1:0] occupied_i,
  sb_wb_if.sink                      wb,
  input  reg_addr_t                  rs1_i,
  output xlen_t                      rs1_o,
  output logic                       rs1_valid_o,
  input  reg_addr_t                  rs2_i,
  output xlen_t                      rs2_o,
  output logic                       rs2_valid_o
);

  // index 0 is rs1, index 1 is rs2
  reg_addr_t [1:0]                              rs_addr;
  xlen_t     [1:0]                              rs_data;
  logic      [1:0]                              rs_hit;
  // write-back lanes first, then slots
  xlen_t     [NR_WB_PORTS+NR_ENTRIES-1:0]       src_data;
  logic      [1:0][NR_WB_PORTS+NR_ENTRIES-1:0]  fwd_req;

  assign rs_addr[0] = rs1_i;
  assign rs_addr[1] = rs2_i;

  // ----------------------------------------
  // request vectors
  // ----------------------------------------
  always_comb begin
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      src_data[p] = wb.data[p];
    end
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      src_data[NR_WB_PORTS+i] = entries_i[i].result;
    end
    for (int unsigned s = 0; s < 2; s++) begin
      // result in flight this cycle, its slot must still be live
      for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
        fwd_req[s][p] = wb.valid[p] && !wb.ex[p] && occupied_i[wb.trans_id[p]]
                        && (entries_i[wb.trans_id[p]].rd == rs_addr[s]);
      end
      // result already parked in a slot
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        fwd_req[s][NR_WB_PORTS+i] = occupied_i[i] && entries_i[i].done
                                    && !entries_i[i].ex_valid
                                    && (entries_i[i].rd == rs_addr[s]);
      end
    end
  end

  for (genvar s = 0; s < 2; s++) begin : gen_src
    sb_prio_select #(
      .N         (NR_WB_PORTS + NR_ENTRIES),
      .payload_t (xlen_t)
    ) i_sel_rs (
      .req_i   (fwd_req[s]),
      .data_i  (src_data),
      .valid_o (rs_hit[s]),
      .data_o  (rs_data[s])
    );
  end

  // x0 reads from the register file
  assign rs1_o       = rs_data[0];
  assign rs1_valid_o = rs_hit[0] & (|rs1_i);
  assign rs2_o       = rs_data[1];
  assign rs2_valid_o = rs_hit[1] & (|rs2_i);

endmodule

`default_nettype wire

//--- rtl/sb_clobber_table.sv
/*
  per-register view of the unit that will write it next
  purely combinational, x0 never reports a pending writer
*/
`timescale 1ns/1ps
`default_nettype none

module sb_clobber_table
  import sb_cfg_pkg::*;
  import sb_instr_pkg::*;
(
  input  sb_entry_t [NR_ENTRIES-1:0] entries_i,
  input  logic      [NR_ENTRIES-1:0] occupied_i,
  output fu_t       [NR_REGS-1:0]    rd_clobber_o
);

  // unit kind of every slot, shared by all selects
  fu_t  [NR_ENTRIES-1:0]              slot_fu;
  // per register, which slots write it
  logic [NR_REGS-1:0][NR_ENTRIES-1:0] clobber_req;

  // ----------------------------------------
  // match destinations
  // ----------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      slot_fu[i] = entries_i[i].fu;
    end
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        clobber_req[r][i] = occupied_i[i] && (entries_i[i].rd == reg_addr_t'(r));
      end
    end
    // x0 is hardwired
    clobber_req[0] = '0;
  end

  // lowest occupied slot decides
  for (genvar r = 0; r < NR_REGS; r++) begin : gen_reg
    sb_prio_select #(
      .N         (NR_ENTRIES),
      .payload_t (fu_t)
    ) i_sel_fu (
      .req_i   (clobber_req[r]),
      .data_i  (slot_fu),
      .valid_o (),
      .data_o  (rd_clobber_o[r])
    );
  end

  // x0 must read free for the issue stage
  a_x0_free: assert final (rd_clobber_o[0] == FU_NONE)
    else $error("register 0 shows a pending writer");

endmodule

`default_nettype wire

//--- rtl/sb_entry_store.sv
/*
  in-order queue of scoreboard entries with issue and commit pointers
  write-backs to empty slots are dropped
  flush wins over accept and commit
*/
`timescale 1ns/1ps
`default_nettype none

module sb_entry_store
  import sb_cfg_pkg::*;
  import sb_instr_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  // decode side
  input  logic                        decoded_valid_i,
  output logic                        decoded_ready_o,
  input  fu_t                         decoded_fu_i,
  input  reg_addr_t                   decoded_rd_i,
  output trans_id_t                   issue_trans_id_o,
  // result buses
  sb_wb_if.sink                       wb,
  // commit side
  output logic                        commit_valid_o,
  input  logic                        commit_ready_i,
  output sb_entry_t                   commit_entry_o,
  output trans_id_t                   commit_trans_id_o,
  // state for the readout blocks
  output sb_entry_t [NR_ENTRIES-1:0]  entries_o,
  output logic      [NR_ENTRIES-1:0]  occupied_o
);

  // one extra bit so a full queue is distinguishable from empty
  typedef logic [ENTRY_BITS:0] cnt_t;

  sb_entry_t [NR_ENTRIES-1:0] mem_q, mem_n;
  logic      [NR_ENTRIES-1:0] occ_q, occ_n;
  trans_id_t                  issue_ptr_q, commit_ptr_q;
  cnt_t                       cnt_q;
  logic                       accept, commit_fire;

  if (NR_ENTRIES != 2 ** ENTRY_BITS) begin : gen_size_check
    $error("scoreboard depth must be a power of two");
  end

  // ----------------------------------------
  // handshakes
  // ----------------------------------------
  assign decoded_ready_o   = (cnt_q < cnt_t'(NR_ENTRIES));
  assign accept            = decoded_valid_i & decoded_ready_o;
  // oldest slot retires once its result is in
  assign commit_valid_o    = occ_q[commit_ptr_q] & mem_q[commit_ptr_q].done;
  assign commit_fire       = commit_valid_o & commit_ready_i;

  assign issue_trans_id_o  = issue_ptr_q;
  assign commit_trans_id_o = commit_ptr_q;
  assign commit_entry_o    = mem_q[commit_ptr_q];
  assign entries_o         = mem_q;
  assign occupied_o        = occ_q;

  // ----------------------------------------
  // next slot contents
  // ----------------------------------------
  always_comb begin
    mem_n = mem_q;
    occ_n = occ_q;

    // new instruction enters at the issue pointer
    if (accept) begin
      mem_n[issue_ptr_q] = '{
        fu:       decoded_fu_i,
        rd:       decoded_rd_i,
        result:   '0,
        done:     1'b0,
        ex_valid: 1'b0
      };
      occ_n[issue_ptr_q] = 1'b1;
    end

    // FU_NONE has no unit to wait for and finishes a cycle after entering
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (occ_q[i] && (mem_q[i].fu == FU_NONE)) begin
        mem_n[i].done = 1'b1;
      end
    end

    // results land only in live slots so stale ones after a flush are lost
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      if (wb.valid[p] && occ_q[wb.trans_id[p]]) begin
        mem_n[wb.trans_id[p]].result   = wb.data[p];
        mem_n[wb.trans_id[p]].ex_valid = wb.ex[p];
        mem_n[wb.trans_id[p]].done     = 1'b1;
      end
    end

    // retire frees the oldest slot
    if (commit_fire) begin
      occ_n[commit_ptr_q]          = 1'b0;
      mem_n[commit_ptr_q].done     = 1'b0;
      mem_n[commit_ptr_q].ex_valid = 1'b0;
    end

    // flush clears the status of every slot
    if (flush_i) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        mem_n[i].done     = 1'b0;
        mem_n[i].ex_valid = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q        <= '0;
      occ_q        <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      mem_q        <= mem_n;
      occ_q        <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      mem_q        <= mem_n;
      occ_q        <= occ_n;
      // pointers wrap by overflow
      issue_ptr_q  <= issue_ptr_q + trans_id_t'(accept);
      commit_ptr_q <= commit_ptr_q + trans_id_t'(commit_fire);
      cnt_q        <= cnt_q + cnt_t'(accept) - cnt_t'(commit_fire);
    end
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  // ready without a valid head must not move the commit pointer
  a_no_idle_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (commit_ready_i && !commit_valid_o && !flush_i) |=> (commit_ptr_q == $past(commit_ptr_q)))
    else $error("commit pointer moved without a valid head");

  // each slot has a single producing unit
  for (genvar a = 0; a < NR_WB_PORTS; a++) begin : gen_wb_uniq
    for (genvar b = a + 1; b < NR_WB_PORTS; b++) begin : gen_wb_pair
      a_wb_uniq: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb.valid[a] && wb.valid[b]) |-> (wb.trans_id[a] != wb.trans_id[b]))
        else $error("two write-back ports hit the same transaction id");
    end
  end

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= cnt_t'(NR_ENTRIES))
    else $error("scoreboard count above depth");

endmodule

`default_nettype wire

//--- rtl/sb_prio_select.sv
/*
  fixed-priority select, lowest request index wins
  payload must be a packed type, zero is returned when nothing requests
*/
`timescale 1ns/1ps
`default_nettype none

module sb_prio_select
  import sb_cfg_pkg::*;
  import sb_instr_pkg::*;
#(
  parameter int unsigned N = NR_ENTRIES,
  parameter type payload_t = fu_t
) (
  input  logic     [N-1:0] req_i,
  input  payload_t [N-1:0] data_i,
  output logic             valid_o,
  output payload_t         data_o
);

  // ----------------------------------------
  // priority scan
  // ----------------------------------------
  // walk from the top down so the lowest index is written last
  always_comb begin
    valid_o = 1'b0;
    data_o  = payload_t'(0);
    for (int i = int'(N) - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        valid_o = 1'b1;
        data_o  = data_i[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/sb_wb_if.sv
/*
  write-back bus, one lane per port
  no back-pressure: a valid lane takes effect at the clock edge
*/
`timescale 1ns/1ps
`default_nettype none

interface sb_wb_if
  import sb_cfg_pkg::*;
();

  // lane valid, one bit per port
  logic      [NR_WB_PORTS-1:0] valid;
  // slot the result belongs to
  trans_id_t [NR_WB_PORTS-1:0] trans_id;
  // result word
  xlen_t     [NR_WB_PORTS-1:0] data;
  // exception raised by the unit
  logic      [NR_WB_PORTS-1:0] ex;

  // driven from the top level pins
  modport src (
    output valid,
    output trans_id,
    output data,
    output ex
  );

  // entry store and forwarding both listen here
  modport sink (
    input valid,
    input trans_id,
    input data,
    input ex
  );

endinterface

`default_nettype wire

//--- rtl/sb_instr_pkg.sv
/*
  instruction side types of the scoreboard
  FU_NONE must encode as zero, an empty clobber select yields it
*/
`default_nettype none

package sb_instr_pkg;

  import sb_cfg_pkg::*;

  // ----------------------------------------
  // unit kinds
  // ----------------------------------------
  // FU_NONE finishes on its own, the others wait for write-back
  typedef enum logic [1:0] {
    FU_NONE = 2'd0,
    FU_ALU  = 2'd1,
    FU_LOAD = 2'd2,
    FU_MULT = 2'd3
  } fu_t;

  // ----------------------------------------
  // queue entry, 41 bits
  // ----------------------------------------
  typedef struct packed {
    // unit that will produce the result
    fu_t       fu;
    // destination register
    reg_addr_t rd;
    // write-back data, zero for FU_NONE
    xlen_t     result;
    // result present, entry may commit
    logic      done;
    // unit reported an exception
    logic      ex_valid;
  } sb_entry_t;

endpackage

`default_nettype wire

//--- rtl/sb_cfg_pkg.sv
/*
  scoreboard sizes and widths, shared by every block
  NR_ENTRIES must stay a power of two since pointers wrap by overflow
*/
`default_nettype none

package sb_cfg_pkg;

  // ----------------------------------------
  // queue geometry
  // ----------------------------------------
  localparam int unsigned NR_ENTRIES    = 8;
  // slot index width, doubles as transaction id width
  localparam int unsigned ENTRY_BITS    = $clog2(NR_ENTRIES);

  // register file and datapath
  localparam int unsigned REG_ADDR_BITS = 5;
  localparam int unsigned NR_REGS       = 2 ** REG_ADDR_BITS;
  localparam int unsigned XLEN          = 32;

  // result buses coming back from the units
  localparam int unsigned NR_WB_PORTS   = 2;

  typedef logic [ENTRY_BITS-1:0]    trans_id_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]          xlen_t;

endpackage

`default_nettype wire
